// File: hw/video_pkg.sv
// ==============================
// video package
// pixel-side beat and per-lane encoder word
// ==============================

package video_pkg;

    // one pixel clock of video input, 27 bits
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        logic       hsync;
        logic       vsync;
        logic       de;     // high during active video
    } video_beat;

    // encoder input for one lane, 11 bits
    typedef struct packed {
        logic [7:0] data;   // colour byte
        logic [1:0] ctrl;   // {c1, c0}, sent in blanking
        logic       de;
    } chan_word;

endpackage

// File: hw/tmds_pkg.sv
// ==============================
// tmds package
// link-side symbol types and control codes
// ==============================

package tmds_pkg;

    localparam int num_lanes  = 3;   // blue, green, red
    localparam int sym_width  = 10;

    typedef logic [sym_width-1:0] tmds_symbol;

    // control symbols, indexed by {c1, c0}
    // each one has 7 transitions so the sink can find symbol boundaries
    localparam tmds_symbol ctrl_sym_00 = 10'b1101010100;
    localparam tmds_symbol ctrl_sym_01 = 10'b0010101011;
    localparam tmds_symbol ctrl_sym_10 = 10'b0101010100;
    localparam tmds_symbol ctrl_sym_11 = 10'b1010101011;

    // three data lanes as seen at the pins, 30 bits
    typedef struct packed {
        tmds_symbol lane2;  // red
        tmds_symbol lane1;  // green
        tmds_symbol lane0;  // blue, carries hsync/vsync
    } tmds_link;

endpackage

// File: hw/dvi_channel_mux.sv
// ==============================
// dvi channel mux
// splits a video beat into three lane words
// ==============================
`timescale 1ns/1ps

module dvi_channel_mux (
    input  logic                                          clk_pix,
    input  logic                                          rst_pix,
    input  video_pkg::video_beat                          video,
    output video_pkg::chan_word [tmds_pkg::num_lanes-1:0] chan
);

    video_pkg::chan_word [tmds_pkg::num_lanes-1:0] chan_d;
    logic [7:0] colour [tmds_pkg::num_lanes];   // colour byte per lane

    // lane order follows dvi: 0 blue, 1 green, 2 red
    always_comb begin
        colour[0] = video.blue;
        colour[1] = video.green;
        colour[2] = video.red;
    end

    always_comb begin
        for (int i = 0; i < tmds_pkg::num_lanes; i++) begin
            chan_d[i].data = colour[i];
            chan_d[i].de   = video.de;  // same enable on every lane
            chan_d[i].ctrl = 2'b00;     // green and red carry no sync
        end
        // only blue carries sync during blanking
        chan_d[0].ctrl = {video.vsync, video.hsync};
    end

    // one register stage, reset leaves every lane in ctrl 00 blanking
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            chan <= '0;
        end else begin
            chan <= chan_d;
        end
    end

endmodule

// File: hw/tmds_encoder.sv
// ==============================
// tmds encoder
// one lane of dvi 8b/10b coding with dc balance
// ==============================
`timescale 1ns/1ps

module tmds_encoder (
    input  logic                clk_pix,
    input  logic                rst_pix,
    input  video_pkg::chan_word chan,
    output tmds_pkg::tmds_symbol sym
);

    // number of ones in a byte, 0..8
    function automatic logic [3:0] count_ones(input logic [7:0] b);
        logic [3:0] n;
        n = '0;
        for (int k = 0; k < 8; k++) begin
            n = n + 4'(b[k]);
        end
        return n;
    endfunction

    // transition minimised word, bit 8 set when xor was used
    function automatic logic [8:0] min_trans(input logic [7:0] d, input logic use_xnor);
        logic [8:0] q;
        q[0] = d[0];
        for (int k = 1; k < 8; k++) begin
            q[k] = use_xnor ? ~(q[k-1] ^ d[k]) : (q[k-1] ^ d[k]);
        end
        q[8] = ~use_xnor;
        return q;
    endfunction

    logic [3:0]        ones_in;     // ones in the colour byte
    logic [3:0]        ones_qm;     // ones in qm[7:0]
    logic              use_xnor;
    logic [8:0]        qm;
    logic signed [4:0] disp;        // ones minus zeros of qm[7:0], -8..8
    logic signed [4:0] two_qm8;     // correction terms from bit 8
    logic signed [4:0] two_nqm8;
    logic signed [4:0] bias_q;      // running disparity of sent symbols
    logic signed [4:0] bias_d;
    tmds_pkg::tmds_symbol sym_d;

    always_comb begin
        ones_in  = count_ones(chan.data);
        use_xnor = (ones_in > 4'd4) || ((ones_in == 4'd4) && !chan.data[0]);
        qm       = min_trans(chan.data, use_xnor);
        ones_qm  = count_ones(qm[7:0]);
        disp     = 5'(ones_qm) + 5'(ones_qm) - 5'd8;
        two_qm8  = qm[8] ? 5'sd2 : 5'sd0;
        two_nqm8 = qm[8] ? 5'sd0 : 5'sd2;
    end

    always_comb begin
        sym_d  = tmds_pkg::ctrl_sym_00;
        bias_d = '0;                                // blanking drops the bias
        if (!chan.de) begin
            case (chan.ctrl)
                2'b00:   sym_d = tmds_pkg::ctrl_sym_00;
                2'b01:   sym_d = tmds_pkg::ctrl_sym_01;
                2'b10:   sym_d = tmds_pkg::ctrl_sym_10;
                default: sym_d = tmds_pkg::ctrl_sym_11;
            endcase
        end else if (bias_q == 5'sd0 || disp == 5'sd0) begin
            // no history to balance against, bit 8 decides
            if (!qm[8]) begin
                sym_d  = {2'b10, ~qm[7:0]};
                bias_d = bias_q - disp;
            end else begin
                sym_d  = {2'b01, qm[7:0]};
                bias_d = bias_q + disp;
            end
        end else if (bias_q[4] == disp[4]) begin
            // word would push the bias further, send it inverted
            sym_d  = {1'b1, qm[8], ~qm[7:0]};
            bias_d = bias_q + two_qm8 - disp;
        end else begin
            sym_d  = {1'b0, qm[8], qm[7:0]};    // word already pulls towards zero
            bias_d = bias_q - two_nqm8 + disp;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            sym    <= tmds_pkg::ctrl_sym_00;
            bias_q <= '0;
        end else begin
            sym    <= sym_d;
            bias_q <= bias_d;
        end
    end

endmodule

// File: hw/tmds_output_stage.sv
// ==============================
// tmds output stage
// lane options and the link register
// ==============================
`timescale 1ns/1ps

module tmds_output_stage #(
    parameter logic [tmds_pkg::num_lanes-1:0] lane_polarity_inv = '0,
    parameter logic [tmds_pkg::num_lanes-1:0] lane_bit_reverse  = '0
) (
    input  logic                                           clk_pix,
    input  logic                                           rst_pix,
    input  tmds_pkg::tmds_symbol [tmds_pkg::num_lanes-1:0] sym,
    output tmds_pkg::tmds_link                             link
);

    // reverse first, then invert, same order as the board wiring
    function automatic tmds_pkg::tmds_symbol lane_opts(
        input tmds_pkg::tmds_symbol s,
        input logic                 rev,
        input logic                 inv
    );
        tmds_pkg::tmds_symbol r;
        for (int k = 0; k < tmds_pkg::sym_width; k++) begin
            r[k] = rev ? s[tmds_pkg::sym_width-1-k] : s[k];
        end
        return inv ? ~r : r;
    endfunction

    tmds_pkg::tmds_symbol [tmds_pkg::num_lanes-1:0] lanes_d;    // symbols after options
    tmds_pkg::tmds_symbol [tmds_pkg::num_lanes-1:0] lanes_rst;  // idle pattern per lane

    always_comb begin
        for (int i = 0; i < tmds_pkg::num_lanes; i++) begin
            lanes_d[i]   = lane_opts(sym[i], lane_bit_reverse[i], lane_polarity_inv[i]);
            lanes_rst[i] = lane_opts(tmds_pkg::ctrl_sym_00, lane_bit_reverse[i],
                                     lane_polarity_inv[i]);
        end
    end

    // lane 2 sits in the top bits, matching the link struct
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            link <= tmds_pkg::tmds_link'(lanes_rst);    // pins idle at ctrl 00
        end else begin
            link <= tmds_pkg::tmds_link'(lanes_d);
        end
    end

endmodule

// File: hw/dvi_tx.sv
// ==============================
// dvi transmitter front end
// video beat in, three tmds symbols out
// ==============================
`timescale 1ns/1ps

module dvi_tx #(
    parameter logic [tmds_pkg::num_lanes-1:0] lane_polarity_inv = '0,  // per-lane p/n swap
    parameter logic [tmds_pkg::num_lanes-1:0] lane_bit_reverse  = '0   // per-lane msb first
) (
    input  logic                 clk_pix,
    input  logic                 rst_pix,
    input  video_pkg::video_beat video,
    output tmds_pkg::tmds_link   link     // 3 cycles after video
);

    video_pkg::chan_word  [tmds_pkg::num_lanes-1:0] chan;  // formatter to encoders
    tmds_pkg::tmds_symbol [tmds_pkg::num_lanes-1:0] sym;   // encoders to output stage

    dvi_channel_mux u_mux (
        .clk_pix (clk_pix),
        .rst_pix (rst_pix),
        .video   (video),
        .chan    (chan)
    );

    // one encoder per lane, each keeps its own bias
    for (genvar i = 0; i < tmds_pkg::num_lanes; i++) begin : g_lane
        tmds_encoder u_enc (
            .clk_pix (clk_pix),
            .rst_pix (rst_pix),
            .chan    (chan[i]),
            .sym     (sym[i])
        );
    end

    tmds_output_stage #(
        .lane_polarity_inv (lane_polarity_inv),
        .lane_bit_reverse  (lane_bit_reverse)
    ) u_out (
        .clk_pix (clk_pix),
        .rst_pix (rst_pix),
        .sym     (sym),
        .link    (link)
    );

endmodule

// File: test/tb_tmds_checker.sv
// ==============================
// tmds checker
// reference model of the dvi_tx pipeline, compares link
// ==============================
`timescale 1ns/1ps

module tb_tmds_checker #(
    parameter logic [2:0] lane_polarity_inv = '0,
    parameter logic [2:0] lane_bit_reverse  = '0
) (
    input  logic                 clk_pix,
    input  logic                 rst_pix,
    input  video_pkg::video_beat video,
    input  tmds_pkg::tmds_link   link,
    input  logic                 report,     // last beat of a test
    input  logic [1:0]           tag,        // 1 record burst, 2 compare burst
    input  logic [95:0]          test_name,
    output int                   err_count,
    output int                   tests_done,
    output int                   tests_failed
);

    // side info that travels with each beat through the model
    typedef struct packed {
        logic        rep;
        logic [1:0]  tag;
        logic        de;
        logic [95:0] name;
    } beat_info;

    video_pkg::video_beat m_beat;       // model of the formatter register
    logic [9:0]  m_sym  [3];            // model of the encoder registers
    logic [9:0]  m_link [3];            // model of the link register
    int          m_bias [3];
    int          disp_run [3];          // disparity of de-high symbols, options removed
    beat_info    info_p [3];
    logic [29:0] burst_q [$];           // link words of the first burst
    logic [29:0] got;
    logic [29:0] want;
    int          nb;
    logic        armed = 1'b0;
    int          errs = 0;
    int          done = 0;
    int          failed = 0;
    int          test_errs = 0;

    assign err_count    = errs;
    assign tests_done   = done;
    assign tests_failed = failed;

    // lane l input as {data, ctrl}, only blue carries sync
    function automatic logic [9:0] lane_word(input video_pkg::video_beat b, input int l);
        case (l)
            0:       return {b.blue, b.vsync, b.hsync};
            1:       return {b.green, 2'b00};
            default: return {b.red, 2'b00};
        endcase
    endfunction

    // dvi 1.0 tmds coding, cnt is ones minus zeros sent so far
    function automatic logic [9:0] tmds_code(input logic [9:0] w, input logic de,
                                             input int cnt_in, output int cnt_out);
        logic [7:0] d;
        logic [8:0] qm;
        logic       sel_xnor;
        logic [9:0] q;
        int         n1_d;
        int         n1;
        int         n0;
        d    = w[9:2];
        n1_d = 0;
        n1   = 0;
        for (int k = 0; k < 8; k++) if (d[k]) n1_d++;
        sel_xnor = (n1_d > 4) || (n1_d == 4 && d[0] == 1'b0);
        qm[0] = d[0];
        for (int k = 1; k < 8; k++) qm[k] = sel_xnor ? (qm[k-1] ~^ d[k]) : (qm[k-1] ^ d[k]);
        qm[8] = ~sel_xnor;
        for (int k = 0; k < 8; k++) if (qm[k]) n1++;
        n0 = 8 - n1;
        if (!de) begin
            cnt_out = 0;                            // blanking clears the history
            case (w[1:0])
                2'b00:   q = tmds_pkg::ctrl_sym_00;
                2'b01:   q = tmds_pkg::ctrl_sym_01;
                2'b10:   q = tmds_pkg::ctrl_sym_10;
                default: q = tmds_pkg::ctrl_sym_11;
            endcase
        end else if (cnt_in == 0 || n1 == n0) begin
            q       = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            cnt_out = qm[8] ? cnt_in + n1 - n0 : cnt_in + n0 - n1;
        end else if ((cnt_in > 0 && n1 > n0) || (cnt_in < 0 && n0 > n1)) begin
            q       = {1'b1, qm[8], ~qm[7:0]};
            cnt_out = cnt_in + (qm[8] ? 2 : 0) + n0 - n1;
        end else begin
            q       = {1'b0, qm[8], qm[7:0]};
            cnt_out = cnt_in - (qm[8] ? 0 : 2) + n1 - n0;
        end
        return q;
    endfunction

    // board options: bit order first, then p/n swap
    function automatic logic [9:0] apply_opts(input logic [9:0] s, input int l);
        logic [9:0] r;
        for (int k = 0; k < 10; k++) r[k] = lane_bit_reverse[l] ? s[9-k] : s[k];
        return lane_polarity_inv[l] ? ~r : r;
    endfunction

    function automatic int sym_disparity(input logic [9:0] s);
        int n;
        n = 0;
        for (int k = 0; k < 10; k++) if (s[k]) n++;
        return 2 * n - 10;
    endfunction

    task automatic note_error();
        errs++;
        test_errs++;
    endtask

    task automatic report_test(input logic [95:0] name);
        done++;
        if (test_errs == 0) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail, %0d errors", name, test_errs);
            failed++;
        end
        test_errs = 0;
    endtask

    always @(posedge clk_pix) begin
        got = link;
        if (armed) begin
            for (int l = 0; l < 3; l++) begin
                if (got[l*10 +: 10] !== m_link[l]) begin
                    $display("error: time %0t signal link.lane%0d expected %h actual %h",
                             $time, l, m_link[l], got[l*10 +: 10]);
                    note_error();
                end
            end
            if (info_p[2].tag == 2'd1) begin
                burst_q.push_back(got);
            end else if (info_p[2].tag == 2'd2) begin
                if (burst_q.size() == 0) begin
                    $display("second burst at %0t is longer than the first one", $time);
                    note_error();
                end else begin
                    want = burst_q.pop_front();
                    if (got !== want) begin
                        $display("error: time %0t signal link expected %h actual %h",
                                 $time, want, got);
                        note_error();
                    end
                end
            end
            for (int l = 0; l < 3; l++) begin
                if (info_p[2].de) begin
                    // inversion flips the sign, reversal keeps it
                    nb = sym_disparity(got[l*10 +: 10]);
                    disp_run[l] += lane_polarity_inv[l] ? -nb : nb;
                    if (disp_run[l] > 10 || disp_run[l] < -10) begin
                        $display("lane %0d running disparity %0d left the range -10..10 at %0t",
                                 l, disp_run[l], $time);
                        note_error();
                    end
                end else begin
                    disp_run[l] = 0;
                end
            end
            if (info_p[2].rep) report_test(info_p[2].name);
        end
        // step the model one clock, later stages first
        if (rst_pix) begin
            m_beat = '0;
            for (int l = 0; l < 3; l++) begin
                m_sym[l]    = tmds_pkg::ctrl_sym_00;
                m_link[l]   = apply_opts(tmds_pkg::ctrl_sym_00, l);
                m_bias[l]   = 0;
                disp_run[l] = 0;
                info_p[l]   = '0;
            end
        end else begin
            for (int l = 0; l < 3; l++) begin
                m_link[l] = apply_opts(m_sym[l], l);
                m_sym[l]  = tmds_code(lane_word(m_beat, l), m_beat.de, m_bias[l], nb);
                m_bias[l] = nb;
            end
            info_p[2] = info_p[1];
            info_p[1] = info_p[0];
            info_p[0] = {report, tag, video.de, test_name};
            m_beat    = video;
        end
        armed = 1'b1;
    end

endmodule

// File: test/tb_dvi_tx.sv
// ==============================
// dvi_tx testbench
// table driven video stimulus into the tmds front end
// ==============================
`timescale 1ns/1ps

module tb_dvi_tx;

    localparam logic [2:0] pol_inv      = 3'b010;  // green lane p/n swapped
    localparam logic [2:0] bit_rev      = 3'b001;  // blue lane msb first
    localparam logic [1:0] mode_plain   = 2'd0;
    localparam logic [1:0] mode_record  = 2'd1;    // checker keeps these link words
    localparam logic [1:0] mode_compare = 2'd2;    // checker compares against them

    typedef struct packed {
        logic [95:0] name;
        logic [1:0]  mode;
        int          count;     // beats in this row
        logic        rnd;       // random colour per beat
        logic [23:0] colour;    // {red, green, blue}
        logic        hs;
        logic        vs;
        logic        de;
    } stim_row;

    logic                 clk_pix;
    logic                 rst_pix;
    video_pkg::video_beat video;
    tmds_pkg::tmds_link   link;
    logic                 report;
    logic [1:0]           tag;
    logic [95:0]          test_name;
    int                   err_count;
    int                   tests_done;
    int                   tests_failed;
    stim_row              rows [$];
    int                   total_beats;

    dvi_tx #(
        .lane_polarity_inv (pol_inv),
        .lane_bit_reverse  (bit_rev)
    ) UUT (
        .clk_pix (clk_pix),
        .rst_pix (rst_pix),
        .video   (video),
        .link    (link)
    );

    tb_tmds_checker #(
        .lane_polarity_inv (pol_inv),
        .lane_bit_reverse  (bit_rev)
    ) u_check (
        .clk_pix      (clk_pix),
        .rst_pix      (rst_pix),
        .video        (video),
        .link         (link),
        .report       (report),
        .tag          (tag),
        .test_name    (test_name),
        .err_count    (err_count),
        .tests_done   (tests_done),
        .tests_failed (tests_failed)
    );

    initial clk_pix = 1'b0;
    always #20 clk_pix = ~clk_pix;     // 40 ns pixel clock

    task automatic add_row(input logic [95:0] name, input logic [1:0] mode, input int count,
                           input logic rnd, input logic [23:0] colour,
                           input logic hs, input logic vs, input logic de);
        rows.push_back({name, mode, count, rnd, colour, hs, vs, de});
        total_beats += count;
    endtask

    task automatic build_table();
        add_row("idle_00",    mode_plain,   4,   1'b0, 24'h000000, 1'b0, 1'b0, 1'b0);
        add_row("hsync_01",   mode_plain,   4,   1'b0, 24'h000000, 1'b1, 1'b0, 1'b0);
        add_row("vsync_10",   mode_plain,   4,   1'b0, 24'h000000, 1'b0, 1'b1, 1'b0);
        add_row("sync_11",    mode_plain,   4,   1'b0, 24'h000000, 1'b1, 1'b1, 1'b0);
        add_row("byte_00",    mode_plain,   3,   1'b0, 24'h000000, 1'b0, 1'b0, 1'b1);
        add_row("byte_ff",    mode_plain,   3,   1'b0, 24'hffffff, 1'b0, 1'b0, 1'b1);
        add_row("byte_0f",    mode_plain,   3,   1'b0, 24'h0f0f0f, 1'b0, 1'b0, 1'b1);  // tie, xor
        add_row("byte_f0",    mode_plain,   3,   1'b0, 24'hf0f0f0, 1'b0, 1'b0, 1'b1);  // tie, xnor
        add_row("byte_55",    mode_plain,   3,   1'b0, 24'h555555, 1'b0, 1'b0, 1'b1);
        add_row("byte_aa",    mode_plain,   3,   1'b0, 24'haaaaaa, 1'b0, 1'b0, 1'b1);
        add_row("random_200", mode_plain,   200, 1'b1, 24'h000000, 1'b0, 1'b0, 1'b1);
        add_row("gap",        mode_plain,   2,   1'b0, 24'h000000, 1'b0, 1'b0, 1'b0);
        add_row("burst_a",    mode_record,  6,   1'b0, 24'h070301, 1'b0, 1'b0, 1'b1);
        add_row("one_blank",  mode_plain,   1,   1'b0, 24'h000000, 1'b0, 1'b0, 1'b0);
        add_row("burst_b",    mode_compare, 6,   1'b0, 24'h070301, 1'b0, 1'b0, 1'b1);
        add_row("tail",       mode_plain,   4,   1'b0, 24'h000000, 1'b0, 1'b0, 1'b0);
    endtask

    function automatic video_pkg::video_beat make_beat(input stim_row r);
        logic [23:0]          c;
        video_pkg::video_beat b;
        c       = r.rnd ? 24'($urandom()) : r.colour;
        b.red   = c[23:16];
        b.green = c[15:8];
        b.blue  = c[7:0];
        b.hsync = r.hs;
        b.vsync = r.vs;
        b.de    = r.de;
        return b;
    endfunction

    initial begin
        void'($urandom(17));
        rst_pix     = 1'b1;
        video       = '0;
        report      = 1'b0;
        tag         = mode_plain;
        test_name   = '0;
        total_beats = 0;
        build_table();
        repeat (2) @(posedge clk_pix);
        rst_pix <= 1'b0;
        foreach (rows[i]) begin
            for (int n = 0; n < rows[i].count; n++) begin
                @(posedge clk_pix);
                video     <= make_beat(rows[i]);
                report    <= (n == rows[i].count - 1);   // checker reports on this beat
                tag       <= rows[i].mode;
                test_name <= rows[i].name;
            end
        end
        @(posedge clk_pix);
        video  <= '0;
        report <= 1'b0;
        tag    <= mode_plain;
        while (tests_done < rows.size()) @(negedge clk_pix);    // last beats still in flight
        $display("tests run %0d, failed %0d, errors %0d", tests_done, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog allows all table beats plus margin for reset and pipeline
    initial begin
        #1;
        #((total_beats + 20) * 40);
        $display("run timed out after %0d cycles with %0d tests done",
                 total_beats + 20, tests_done);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: all.f
hw/video_pkg.sv
hw/tmds_pkg.sv
hw/dvi_channel_mux.sv
hw/tmds_encoder.sv
hw/tmds_output_stage.sv
hw/dvi_tx.sv
test/tb_tmds_checker.sv
test/tb_dvi_tx.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dvi_tx testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -j 0 --top-module tb_dvi_tx -f all.f -o sim_dvi_tx
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_dvi_tx > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" "$log"; then
    exit 0
else
    echo "pass message not found in $log"
    exit 1
fi
